/* hdl/conv2d_pkg.sv */
package conv2d_pkg;

    localparam int DWIDTH            = 32;
    localparam int AWIDTH            = 32;
    localparam int WT_DIM            = 3;
    localparam int MAX_FM_DIM        = 12;
    localparam int PE_FIFO_LOGDEPTH  = 5;
    localparam int IN_FIFO_LOGDEPTH  = 4;
    localparam int OUT_FIFO_LOGDEPTH = 8;

    typedef logic signed [DWIDTH-1:0] data_t;
    typedef logic [7:0]               dim_t;

    // one burst with len counted in words
    typedef struct packed {
        logic [AWIDTH-1:0] addr;
        logic [31:0]       len;
    } mem_req_t;

    typedef struct packed {
        dim_t              fm_dim;
        logic [AWIDTH-1:0] wt_offset;
        logic [AWIDTH-1:0] ifm_offset;
        logic [AWIDTH-1:0] ofm_offset;
    } conv_cfg_t;

    typedef struct packed {
        data_t data;
        dim_t  row;
        dim_t  col;
    } wt_beat_t;

    // coordinates are in the padded grid
    typedef struct packed {
        data_t data;
        dim_t  x;
        dim_t  y;
    } pix_t;

    typedef enum logic [2:0] {
        IDLE,
        LOAD_WT,
        LOAD_FM,
        DRAIN,
        STORE_ADDR,
        STORE_DATA,
        WAIT_RESP
    } ctrl_state_t;

endpackage

/* hdl/stream_fifo.sv */
`timescale 1ns/10ps

module stream_fifo #(
    parameter int LOGDEPTH = 4
) (
    input  logic              clk,
    input  logic              write_counter_rst,
    input  conv2d_pkg::data_t enq_data,
    input  logic              enq_valid,
    output logic              enq_ready,
    output conv2d_pkg::data_t deq_data,
    output logic              deq_valid,
    input  logic              deq_ready
);
    import conv2d_pkg::*;

    data_t               mem [2**LOGDEPTH];
    logic [LOGDEPTH-1:0] wr_ptr;
    logic [LOGDEPTH-1:0] rd_ptr;
    logic [LOGDEPTH:0]   count;
    logic                enq_fire;
    logic                deq_fire;

    // top bit of count set means full
    assign enq_ready = ~count[LOGDEPTH];
    assign deq_valid = (count != '0);
    assign deq_data  = mem[rd_ptr];

    assign enq_fire = enq_valid & enq_ready;
    assign deq_fire = deq_valid & deq_ready;

    always_ff @(posedge clk) begin
        if (enq_fire) begin
            mem[wr_ptr] <= enq_data;
        end
    end

    always_ff @(posedge clk) begin
        if (write_counter_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (enq_fire) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (deq_fire) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + {{LOGDEPTH{1'b0}}, enq_fire} - {{LOGDEPTH{1'b0}}, deq_fire};
        end
    end

    // pointer distance tracks the occupancy
    a_ptr_count: assert property (@(posedge clk) disable iff (write_counter_rst)
        ((wr_ptr - rd_ptr) == count[LOGDEPTH-1:0]));

endmodule

/* hdl/conv2d_pe.sv */
`timescale 1ns/10ps

module conv2d_pe #(
    parameter int PE_ROW = 0
) (
    input  logic                 clk,
    input  logic                 write_counter_rst,
    input  conv2d_pkg::dim_t     fm_dim,
    input  conv2d_pkg::wt_beat_t weight,
    input  logic                 weight_valid,
    input  conv2d_pkg::pix_t     pix,
    input  logic                 pix_valid,
    output logic                 pix_ready,
    output conv2d_pkg::data_t    psum,
    output logic                 psum_valid,
    input  logic                 psum_ready
);
    import conv2d_pkg::*;

    data_t w   [WT_DIM];
    data_t win [WT_DIM-1];
    logic  sum_due;
    logic  pix_fire;

    // kernel row for this PE
    always_ff @(posedge clk) begin
        if (write_counter_rst) begin
            for (int k = 0; k < WT_DIM; k++) begin
                w[k] <= '0;
            end
        end else if (weight_valid && (weight.row == dim_t'(PE_ROW))) begin
            for (int k = 0; k < WT_DIM; k++) begin
                if (weight.col == dim_t'(k)) begin
                    w[k] <= weight.data;
                end
            end
        end
    end

    // previous pixels of the current padded row with the oldest first
    always_ff @(posedge clk) begin
        if (pix_fire) begin
            for (int k = 0; k < WT_DIM - 2; k++) begin
                win[k] <= win[k+1];
            end
            win[WT_DIM-2] <= pix.data;
        end
    end

    // full window and a padded row that this kernel row touches
    assign sum_due = (pix.x >= dim_t'(WT_DIM - 1))
                   && (pix.y >= dim_t'(PE_ROW))
                   && (pix.y < fm_dim + dim_t'(PE_ROW));

    assign pix_ready  = !sum_due || psum_ready;
    assign pix_fire   = pix_valid && pix_ready;
    assign psum_valid = pix_valid && sum_due;

    always_comb begin
        data_t acc;
        acc = w[WT_DIM-1] * pix.data;
        for (int k = 0; k < WT_DIM - 1; k++) begin
            acc = acc + w[k] * win[k];
        end
        psum = acc;
    end

endmodule

/* hdl/conv2d_ctrl.sv */
`timescale 1ns/10ps

module conv2d_ctrl (
    input  logic                          clk,
    input  logic                          write_counter_rst,
    input  logic                          start,
    input  conv2d_pkg::conv_cfg_t         cfg,
    output logic                          idle,
    output logic                          write_error,
    output conv2d_pkg::mem_req_t          rd_req,
    output logic                          rd_req_valid,
    input  logic                          rd_req_ready,
    input  conv2d_pkg::data_t             in_data,
    input  logic                          in_valid,
    output logic                          in_ready,
    output conv2d_pkg::wt_beat_t          weight,
    output logic                          weight_valid,
    output conv2d_pkg::pix_t              pix,
    output logic                          pix_valid,
    input  logic [conv2d_pkg::WT_DIM-1:0] pe_ready,
    input  logic                          results_done,
    output conv2d_pkg::mem_req_t          wr_req,
    output logic                          wr_req_valid,
    input  logic                          wr_req_ready,
    input  logic                          out_drained,
    input  logic                          resp_status,
    input  logic                          resp_valid,
    output logic                          resp_ready
);
    import conv2d_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_next;
    conv_cfg_t   cfg_q;
    dim_t        row_cnt;
    dim_t        col_cnt;
    dim_t        x_cnt;
    dim_t        y_cnt;
    dim_t        fm_edge;
    logic [31:0] fm_area;
    logic        halo;
    logic        wt_fire;
    logic        wt_last;
    logic        pix_last;

    assign fm_edge = cfg_q.fm_dim + 8'd1;
    assign fm_area = 32'(cfg_q.fm_dim) * 32'(cfg_q.fm_dim);

    assign halo = (x_cnt == '0) || (y_cnt == '0) || (x_cnt == fm_edge) || (y_cnt == fm_edge);

    // weights have no back-pressure
    assign wt_fire  = (state == LOAD_WT) && in_valid;
    assign wt_last  = wt_fire && (row_cnt == dim_t'(WT_DIM - 1))
                    && (col_cnt == dim_t'(WT_DIM - 1));
    assign pix_valid = (state == LOAD_FM) && (halo || in_valid) && (&pe_ready);
    assign pix_last  = pix_valid && (x_cnt == fm_edge) && (y_cnt == fm_edge);

    // halo pixels leave read data in place
    assign in_ready = (state == LOAD_WT) || ((state == LOAD_FM) && !halo && (&pe_ready));

    assign weight_valid = wt_fire;
    assign weight       = '{data: in_data, row: row_cnt, col: col_cnt};
    assign pix          = '{data: halo ? data_t'(0) : in_data, x: x_cnt, y: y_cnt};

    assign rd_req.addr  = (state == LOAD_FM) ? cfg_q.ifm_offset : cfg_q.wt_offset;
    assign rd_req.len   = (state == LOAD_FM) ? fm_area : 32'(WT_DIM * WT_DIM);
    assign wr_req       = '{addr: cfg_q.ofm_offset, len: fm_area};
    assign wr_req_valid = (state == STORE_ADDR);
    assign resp_ready   = (state == WAIT_RESP);
    assign idle         = (state == IDLE);

    always_comb begin
        state_next = state;
        case (state)
            IDLE:       if (start) state_next = LOAD_WT;
            LOAD_WT:    if (wt_last) state_next = LOAD_FM;
            LOAD_FM:    if (pix_last) state_next = DRAIN;
            DRAIN:      if (results_done) state_next = STORE_ADDR;
            STORE_ADDR: if (wr_req_ready) state_next = STORE_DATA;
            STORE_DATA: if (out_drained) state_next = WAIT_RESP;
            WAIT_RESP:  if (resp_valid) state_next = IDLE;
            default:    state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (write_counter_rst) begin
            state        <= IDLE;
            rd_req_valid <= 1'b0;
            write_error  <= 1'b0;
        end else begin
            state <= state_next;
            // one read burst per load phase
            if ((idle && start) || wt_last) begin
                rd_req_valid <= 1'b1;
            end else if (rd_req_ready) begin
                rd_req_valid <= 1'b0;
            end
            if (resp_ready && resp_valid) begin
                write_error <= resp_status;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (idle && start) begin
            cfg_q <= cfg;
        end
    end

    always_ff @(posedge clk) begin
        if (write_counter_rst || idle) begin
            row_cnt <= '0;
            col_cnt <= '0;
            x_cnt   <= '0;
            y_cnt   <= '0;
        end else begin
            if (wt_fire) begin
                if (col_cnt == dim_t'(WT_DIM - 1)) begin
                    col_cnt <= '0;
                    row_cnt <= (row_cnt == dim_t'(WT_DIM - 1)) ? '0 : row_cnt + 8'd1;
                end else begin
                    col_cnt <= col_cnt + 8'd1;
                end
            end
            if (pix_valid) begin
                if (x_cnt == fm_edge) begin
                    x_cnt <= '0;
                    y_cnt <= (y_cnt == fm_edge) ? '0 : y_cnt + 8'd1;
                end else begin
                    x_cnt <= x_cnt + 8'd1;
                end
            end
        end
    end

    a_fm_dim_range: assert property (@(posedge clk) disable iff (write_counter_rst)
        (idle && start) |-> ((cfg.fm_dim >= 8'd1) && (cfg.fm_dim <= dim_t'(MAX_FM_DIM))));

    a_rd_req_hold: assert property (@(posedge clk) disable iff (write_counter_rst)
        (rd_req_valid && !rd_req_ready) |=> (rd_req_valid && $stable(rd_req)));

endmodule

/* hdl/conv2d_row_adder.sv */
`timescale 1ns/10ps

module conv2d_row_adder (
    input  logic                          clk,
    input  logic                          write_counter_rst,
    input  logic                          start,
    input  conv2d_pkg::dim_t              fm_dim,
    input  conv2d_pkg::data_t             head_data [conv2d_pkg::WT_DIM],
    input  logic [conv2d_pkg::WT_DIM-1:0] head_valid,
    output logic [conv2d_pkg::WT_DIM-1:0] head_ready,
    output conv2d_pkg::data_t             sum,
    output logic                          sum_valid,
    input  logic                          sum_ready,
    output logic                          results_done
);
    import conv2d_pkg::*;

    logic [15:0] sum_cnt;
    logic [15:0] target;
    logic        fire;

    assign target = 16'(fm_dim) * 16'(fm_dim);

    // all rows pop together
    assign sum_valid  = &head_valid;
    assign fire       = sum_valid && sum_ready;
    assign head_ready = {WT_DIM{fire}};

    always_comb begin
        data_t acc;
        acc = '0;
        for (int k = 0; k < WT_DIM; k++) begin
            acc = acc + head_data[k];
        end
        sum = acc;
    end

    always_ff @(posedge clk) begin
        if (write_counter_rst || start) begin
            sum_cnt      <= '0;
            results_done <= 1'b0;
        end else if (fire) begin
            sum_cnt <= sum_cnt + 16'd1;
            if (sum_cnt + 16'd1 == target) begin
                results_done <= 1'b1;
            end
        end
    end

    // every PE stream is exhausted once the last output is formed
    a_done_heads_empty: assert property (@(posedge clk) disable iff (write_counter_rst)
        results_done |-> !(|head_valid));

endmodule

/* hdl/conv2d_compute.sv */
`timescale 1ns/10ps

module conv2d_compute (
    input  logic                  clk,
    input  logic                  write_counter_rst,
    input  logic                  start,
    input  conv2d_pkg::conv_cfg_t cfg,
    output logic                  idle,
    output logic                  write_error,

    // read address
    output conv2d_pkg::mem_req_t  rd_req,
    output logic                  rd_req_valid,
    input  logic                  rd_req_ready,

    // read data
    input  conv2d_pkg::data_t     rdata,
    input  logic                  rdata_valid,
    output logic                  rdata_ready,

    // write address
    output conv2d_pkg::mem_req_t  wr_req,
    output logic                  wr_req_valid,
    input  logic                  wr_req_ready,

    // write data
    output conv2d_pkg::data_t     wdata,
    output logic                  wdata_valid,
    input  logic                  wdata_ready,

    // write response
    input  logic                  resp_status,
    input  logic                  resp_valid,
    output logic                  resp_ready
);
    import conv2d_pkg::*;

    data_t              in_data;
    logic               in_valid;
    logic               in_ready;
    wt_beat_t           weight;
    logic               weight_valid;
    pix_t               pix;
    logic               pix_valid;
    logic [WT_DIM-1:0]  pe_ready;
    data_t              pe_psum [WT_DIM];
    logic [WT_DIM-1:0]  pe_psum_valid;
    logic [WT_DIM-1:0]  pe_psum_ready;
    data_t              head_data [WT_DIM];
    logic [WT_DIM-1:0]  head_valid;
    logic [WT_DIM-1:0]  head_ready;
    data_t              sum;
    logic               sum_valid;
    logic               sum_ready;
    logic               results_done;

    stream_fifo #(.LOGDEPTH(IN_FIFO_LOGDEPTH)) in_fifo (
        .clk               (clk),
        .write_counter_rst (write_counter_rst),
        .enq_data          (rdata),
        .enq_valid         (rdata_valid),
        .enq_ready         (rdata_ready),
        .deq_data          (in_data),
        .deq_valid         (in_valid),
        .deq_ready         (in_ready)
    );

    conv2d_ctrl ctrl (
        .clk               (clk),
        .write_counter_rst (write_counter_rst),
        .start             (start),
        .cfg               (cfg),
        .idle              (idle),
        .write_error       (write_error),
        .rd_req            (rd_req),
        .rd_req_valid      (rd_req_valid),
        .rd_req_ready      (rd_req_ready),
        .in_data           (in_data),
        .in_valid          (in_valid),
        .in_ready          (in_ready),
        .weight            (weight),
        .weight_valid      (weight_valid),
        .pix               (pix),
        .pix_valid         (pix_valid),
        .pe_ready          (pe_ready),
        .results_done      (results_done),
        .wr_req            (wr_req),
        .wr_req_valid      (wr_req_valid),
        .wr_req_ready      (wr_req_ready),
        .out_drained       (!wdata_valid),
        .resp_status       (resp_status),
        .resp_valid        (resp_valid),
        .resp_ready        (resp_ready)
    );

    // one PE and one partial-sum FIFO per kernel row
    for (genvar i = 0; i < WT_DIM; i++) begin : g_pe
        conv2d_pe #(.PE_ROW(i)) pe (
            .clk               (clk),
            .write_counter_rst (write_counter_rst),
            .fm_dim            (cfg.fm_dim),
            .weight            (weight),
            .weight_valid      (weight_valid),
            .pix               (pix),
            .pix_valid         (pix_valid),
            .pix_ready         (pe_ready[i]),
            .psum              (pe_psum[i]),
            .psum_valid        (pe_psum_valid[i]),
            .psum_ready        (pe_psum_ready[i])
        );

        stream_fifo #(.LOGDEPTH(PE_FIFO_LOGDEPTH)) pe_fifo (
            .clk               (clk),
            .write_counter_rst (write_counter_rst),
            .enq_data          (pe_psum[i]),
            .enq_valid         (pe_psum_valid[i]),
            .enq_ready         (pe_psum_ready[i]),
            .deq_data          (head_data[i]),
            .deq_valid         (head_valid[i]),
            .deq_ready         (head_ready[i])
        );
    end

    conv2d_row_adder adder (
        .clk               (clk),
        .write_counter_rst (write_counter_rst),
        .start             (start),
        .fm_dim            (cfg.fm_dim),
        .head_data         (head_data),
        .head_valid        (head_valid),
        .head_ready        (head_ready),
        .sum               (sum),
        .sum_valid         (sum_valid),
        .sum_ready         (sum_ready),
        .results_done      (results_done)
    );

    stream_fifo #(.LOGDEPTH(OUT_FIFO_LOGDEPTH)) out_fifo (
        .clk               (clk),
        .write_counter_rst (write_counter_rst),
        .enq_data          (sum),
        .enq_valid         (sum_valid),
        .enq_ready         (sum_ready),
        .deq_data          (wdata),
        .deq_valid         (wdata_valid),
        .deq_ready         (wdata_ready)
    );

endmodule

/* test/tb_mem_model.sv */
`timescale 1ns/10ps

module tb_mem_model (
    input  logic                 clk,
    input  logic                 write_counter_rst,
    input  logic                 stall_mode,
    input  logic                 resp_code,
    input  logic                 load_en,
    input  logic [31:0]          load_addr,
    input  conv2d_pkg::data_t    load_data,
    input  logic                 log_clear,
    input  conv2d_pkg::mem_req_t rd_req,
    input  logic                 rd_req_valid,
    output logic                 rd_req_ready,
    output conv2d_pkg::data_t    rdata,
    output logic                 rdata_valid,
    input  logic                 rdata_ready,
    input  conv2d_pkg::mem_req_t wr_req,
    input  logic                 wr_req_valid,
    output logic                 wr_req_ready,
    input  conv2d_pkg::data_t    wdata,
    input  logic                 wdata_valid,
    output logic                 wdata_ready,
    output logic                 resp_status,
    output logic                 resp_valid,
    input  logic                 resp_ready
);
    import conv2d_pkg::*;

    localparam int MEM_WORDS = 4096;

    data_t       mem [MEM_WORDS];
    logic [11:0] rd_addr = '0;
    logic [31:0] rd_left = '0;
    logic        rd_gate = 1'b0;
    logic [11:0] wr_addr = '0;
    logic [31:0] wr_left = '0;
    logic        wr_stall = 1'b0;
    integer      seed = 42231;

    // request log for the testbench
    logic [31:0] rd_addr_log [2];
    logic [31:0] rd_len_log [2];
    int          rd_count;
    logic [31:0] wr_addr_log;
    logic [31:0] wr_len_log;
    int          wr_words;

    initial begin
        resp_valid  = 1'b0;
        resp_status = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = data_t'(32'h5a000000 ^ (i * 32'h00010001));
        end
    end

    assign rd_req_ready = (rd_left == 0);
    assign rdata        = mem[rd_addr];
    assign rdata_valid  = (rd_left != 0) && rd_gate;
    assign wr_req_ready = (wr_left == 0) && !resp_valid && !wr_stall;
    assign wdata_ready  = (wr_left != 0) && !wr_stall;

    always @(posedge clk) begin
        if (write_counter_rst) begin
            rd_left     <= '0;
            rd_gate     <= 1'b0;
            wr_left     <= '0;
            wr_stall    <= 1'b0;
            resp_valid  <= 1'b0;
            resp_status <= 1'b0;
        end else begin
            // gate only changes once the current word is gone
            if (!rdata_valid || rdata_ready) begin
                rd_gate <= !(stall_mode && (($random(seed) & 3) == 0));
            end
            wr_stall <= stall_mode && (($random(seed) & 3) == 0);
            if (rd_req_valid && rd_req_ready) begin
                rd_addr <= rd_req.addr[11:0];
                rd_left <= rd_req.len;
            end else if (rdata_valid && rdata_ready) begin
                rd_addr <= rd_addr + 12'd1;
                rd_left <= rd_left - 32'd1;
            end
            if (wr_req_valid && wr_req_ready) begin
                wr_addr <= wr_req.addr[11:0];
                wr_left <= wr_req.len;
            end else if (wdata_valid && wdata_ready) begin
                mem[wr_addr] <= wdata;
                wr_addr      <= wr_addr + 12'd1;
                wr_left      <= wr_left - 32'd1;
                if (wr_left == 32'd1) begin
                    resp_valid  <= 1'b1;
                    resp_status <= resp_code;
                end
            end
            if (resp_valid && resp_ready) begin
                resp_valid <= 1'b0;
            end
            if (load_en) begin
                mem[load_addr[11:0]] <= load_data;
            end
        end
    end

    always @(posedge clk) begin
        if (log_clear) begin
            rd_count <= 0;
            wr_words <= 0;
        end else begin
            if (rd_req_valid && rd_req_ready) begin
                if (rd_count < 2) begin
                    rd_addr_log[rd_count] <= rd_req.addr;
                    rd_len_log[rd_count]  <= rd_req.len;
                end
                rd_count <= rd_count + 1;
            end
            if (wr_req_valid && wr_req_ready) begin
                wr_addr_log <= wr_req.addr;
                wr_len_log  <= wr_req.len;
            end
            if (wdata_valid && wdata_ready) begin
                wr_words <= wr_words + 1;
            end
        end
    end

endmodule

/* test/tb_conv2d.sv */
`timescale 1ns/10ps

module tb_conv2d;
    import conv2d_pkg::*;

    localparam int NUM_TESTS   = 6;
    localparam int TEST_CYCLES = 4000;
    localparam int FM_WORDS    = MAX_FM_DIM * MAX_FM_DIM;
    localparam int CENTRE      = (WT_DIM * WT_DIM) / 2;

    logic        clk;
    logic        write_counter_rst;
    logic        start;
    conv_cfg_t   cfg;
    logic        idle;
    logic        write_error;
    mem_req_t    rd_req;
    logic        rd_req_valid;
    logic        rd_req_ready;
    data_t       rdata;
    logic        rdata_valid;
    logic        rdata_ready;
    mem_req_t    wr_req;
    logic        wr_req_valid;
    logic        wr_req_ready;
    data_t       wdata;
    logic        wdata_valid;
    logic        wdata_ready;
    logic        resp_status;
    logic        resp_valid;
    logic        resp_ready;
    logic        stall_mode;
    logic        resp_code;
    logic        load_en;
    logic [31:0] load_addr;
    data_t       load_data;
    logic        log_clear;

    data_t  wts [WT_DIM*WT_DIM];
    data_t  ifm [FM_WORDS];
    data_t  expected [FM_WORDS];
    integer seed = 42231;

    conv2d_compute dut0 (
        .clk               (clk),
        .write_counter_rst (write_counter_rst),
        .start             (start),
        .cfg               (cfg),
        .idle              (idle),
        .write_error       (write_error),
        .rd_req            (rd_req),
        .rd_req_valid      (rd_req_valid),
        .rd_req_ready      (rd_req_ready),
        .rdata             (rdata),
        .rdata_valid       (rdata_valid),
        .rdata_ready       (rdata_ready),
        .wr_req            (wr_req),
        .wr_req_valid      (wr_req_valid),
        .wr_req_ready      (wr_req_ready),
        .wdata             (wdata),
        .wdata_valid       (wdata_valid),
        .wdata_ready       (wdata_ready),
        .resp_status       (resp_status),
        .resp_valid        (resp_valid),
        .resp_ready        (resp_ready)
    );

    tb_mem_model mem0 (
        .clk               (clk),
        .write_counter_rst (write_counter_rst),
        .stall_mode        (stall_mode),
        .resp_code         (resp_code),
        .load_en           (load_en),
        .load_addr         (load_addr),
        .load_data         (load_data),
        .log_clear         (log_clear),
        .rd_req            (rd_req),
        .rd_req_valid      (rd_req_valid),
        .rd_req_ready      (rd_req_ready),
        .rdata             (rdata),
        .rdata_valid       (rdata_valid),
        .rdata_ready       (rdata_ready),
        .wr_req            (wr_req),
        .wr_req_valid      (wr_req_valid),
        .wr_req_ready      (wr_req_ready),
        .wdata             (wdata),
        .wdata_valid       (wdata_valid),
        .wdata_ready       (wdata_ready),
        .resp_status       (resp_status),
        .resp_valid        (resp_valid),
        .resp_ready        (resp_ready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        repeat (NUM_TESTS * TEST_CYCLES) @(posedge clk);
        report_failure("watchdog expired, the tests did not finish in the allowed time");
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expect_val);
        if (actual !== expect_val) begin
            report_failure($sformatf("mismatch at %0t: %s is 0x%08h, expected 0x%08h",
                                     $time, name, actual, expect_val));
        end
    endtask

    // zero padded correlation wrapping in 32 bits
    function automatic void compute_expected(input int fm);
        data_t acc;
        int    pr;
        int    pc;
        for (int r = 0; r < fm; r++) begin
            for (int c = 0; c < fm; c++) begin
                acc = '0;
                for (int i = 0; i < WT_DIM; i++) begin
                    for (int j = 0; j < WT_DIM; j++) begin
                        pr = r + i - 1;
                        pc = c + j - 1;
                        if (pr >= 0 && pr < fm && pc >= 0 && pc < fm) begin
                            acc = acc + wts[i*WT_DIM+j] * ifm[pr*fm+pc];
                        end
                    end
                end
                expected[r*fm+c] = acc;
            end
        end
    endfunction

    task automatic fill_random(input int fm);
        for (int k = 0; k < WT_DIM * WT_DIM; k++) begin
            wts[k] = data_t'($random(seed));
        end
        for (int k = 0; k < fm * fm; k++) begin
            ifm[k] = data_t'($random(seed));
        end
    endtask

    task automatic write_mem_word(input logic [31:0] addr, input data_t data);
        @(negedge clk);
        load_en   = 1'b1;
        load_addr = addr;
        load_data = data;
    endtask

    task automatic load_job(input int fm, input logic [31:0] wt_base,
                            input logic [31:0] ifm_base);
        for (int k = 0; k < WT_DIM * WT_DIM; k++) begin
            write_mem_word(wt_base + k, wts[k]);
        end
        for (int k = 0; k < fm * fm; k++) begin
            write_mem_word(ifm_base + k, ifm[k]);
        end
        @(negedge clk);
        load_en = 1'b0;
    endtask

    task automatic run_job(input int fm, input logic [31:0] wt_base,
                           input logic [31:0] ifm_base, input logic [31:0] ofm_base);
        int waited;
        load_job(fm, wt_base, ifm_base);
        compute_expected(fm);
        @(negedge clk);
        cfg       = '{fm_dim: dim_t'(fm), wt_offset: wt_base, ifm_offset: ifm_base,
                      ofm_offset: ofm_base};
        start     = 1'b1;
        log_clear = 1'b1;
        @(negedge clk);
        start     = 1'b0;
        log_clear = 1'b0;
        check("idle", 32'(idle), 32'd0);
        check("rd_req_valid", 32'(rd_req_valid), 32'd1);
        waited = 0;
        while (!idle) begin
            @(negedge clk);
            waited++;
            if (waited > TEST_CYCLES) begin
                report_failure($sformatf("the %0dx%0d job never returned to idle", fm, fm));
            end
        end
        check("read bursts", mem0.rd_count, 32'd2);
        check("weight read addr", mem0.rd_addr_log[0], wt_base);
        check("weight read len", mem0.rd_len_log[0], 32'd9);
        check("map read addr", mem0.rd_addr_log[1], ifm_base);
        check("map read len", mem0.rd_len_log[1], 32'(fm * fm));
        check("write addr", mem0.wr_addr_log, ofm_base);
        check("write len", mem0.wr_len_log, 32'(fm * fm));
        check("words written", mem0.wr_words, 32'(fm * fm));
        check("write_error", 32'(write_error), 32'(resp_code));
        for (int k = 0; k < fm * fm; k++) begin
            check($sformatf("ofm[%0d]", k), mem0.mem[ofm_base + k], expected[k]);
        end
    endtask

    task automatic identity_after_reset();
        check("idle", 32'(idle), 32'd1);
        check("rd_req_valid", 32'(rd_req_valid), 32'd0);
        check("wr_req_valid", 32'(wr_req_valid), 32'd0);
        check("wdata_valid", 32'(wdata_valid), 32'd0);
        check("resp_ready", 32'(resp_ready), 32'd0);
        check("write_error", 32'(write_error), 32'd0);
        check("rdata_ready", 32'(rdata_ready), 32'd1);
        for (int k = 0; k < WT_DIM * WT_DIM; k++) begin
            wts[k] = (k == CENTRE) ? data_t'(1) : data_t'(0);
        end
        for (int k = 0; k < 16; k++) begin
            ifm[k] = data_t'(k * 7 - 20);
        end
        run_job(4, 32'd16, 32'd64, 32'd1024);
        for (int k = 0; k < 16; k++) begin
            check($sformatf("identity ofm[%0d]", k), mem0.mem[1024 + k], ifm[k]);
        end
    endtask

    task automatic ones_kernel_halo();
        for (int k = 0; k < WT_DIM * WT_DIM; k++) begin
            wts[k] = data_t'(1);
        end
        for (int k = 0; k < 36; k++) begin
            ifm[k] = data_t'(k + 1);
        end
        run_job(6, 32'd16, 32'd64, 32'd1280);
        // top left corner sees only four pixels
        check("corner sum", mem0.mem[1280], ifm[0] + ifm[1] + ifm[6] + ifm[7]);
    endtask

    task automatic random_weights_map();
        fill_random(MAX_FM_DIM);
        run_job(MAX_FM_DIM, 32'd32, 32'd256, 32'd1536);
    endtask

    task automatic stalled_memory_map();
        stall_mode = 1'b1;
        run_job(MAX_FM_DIM, 32'd32, 32'd256, 32'd1792);
        stall_mode = 1'b0;
    endtask

    task automatic single_pixel_bursts();
        fill_random(1);
        run_job(1, 32'd48, 32'd400, 32'd2048);
        check("1x1 result", mem0.mem[2048], wts[CENTRE] * ifm[0]);
    endtask

    task automatic write_error_recovery();
        resp_code = 1'b1;
        fill_random(5);
        run_job(5, 32'd16, 32'd64, 32'd2304);
        @(negedge clk);
        check("idle after error", 32'(idle), 32'd1);
        check("write_error held", 32'(write_error), 32'd1);
        resp_code = 1'b0;
        fill_random(7);
        run_job(7, 32'd32, 32'd128, 32'd2560);
    endtask

    initial begin
        write_counter_rst = 1'b1;
        start             = 1'b0;
        cfg               = '0;
        stall_mode        = 1'b0;
        resp_code         = 1'b0;
        load_en           = 1'b0;
        load_addr         = '0;
        load_data         = '0;
        log_clear         = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        write_counter_rst = 1'b0;
        @(negedge clk);
        identity_after_reset();
        ones_kernel_halo();
        random_weights_map();
        stalled_memory_map();
        single_pixel_bursts();
        write_error_recovery();
        $display("Testbench passed");
        $finish;
    end

endmodule

/* compile.f */
hdl/conv2d_pkg.sv
hdl/stream_fifo.sv
hdl/conv2d_pe.sv
hdl/conv2d_ctrl.sv
hdl/conv2d_row_adder.sv
hdl/conv2d_compute.sv
test/tb_mem_model.sv
test/tb_conv2d.sv

/* Makefile */
# Verilator flow for the convolution engine testbench
# override on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_conv2d
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_TEXT ?= Testbench passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# the simulator status is ignored here, the log decides
sim: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "$(PASS_TEXT)" $(LOG); then \
		echo "simulation result: pass"; \
	else \
		echo "simulation result: pass message not found in $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
